/* cmd_phys.f */
+incdir+hdl
hdl/sd_cmd_pkg.sv
hdl/cmd_serializer.sv
hdl/cmd_deserializer.sv
hdl/cmd_pad.sv
hdl/cmd_phys_controller.sv
hdl/cmd_phys.sv
bench/sd_card_model.sv
bench/cmd_phys_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cmd_phys testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module cmd_phys_tb \
	-f cmd_phys.f -o cmd_phys_sim; then
	echo "build failed"
	exit 1
fi

./obj_dir/cmd_phys_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "no result line found in sim.log"
	exit 1
fi
exit 0

/* bench/cmd_phys_tb.sv */
`timescale 1ns/1ps
`include "sd_cmd_defines.svh"

module cmd_phys_tb import sd_cmd_pkg::*; ();

	// 8 directed commands plus 20 random ones
	localparam int num_commands = 28;
	localparam int max_cycles = 300 * num_commands + 1000;

	typedef struct packed {
		sd_frame_t  frame;
		sd_resp_t   resp;
		logic       strobe;
		logic       timeout;
		logic       steady;
		logic [7:0] acks;
	} outcome_t;

	logic      sd_clock;
	logic      reset;
	logic      strobe_in;
	logic      ack_in;
	logic      idle_in;
	sd_cmd_t   cmd_to_send;
	logic      ack_out;
	logic      strobe_out;
	sd_resp_t  response;
	logic      command_timeout;
	wire       cmd_pin;

	logic      card_answer;
	sd_resp_t  card_resp;
	sd_len_t   card_len;
	int        card_gap;
	sd_frame_t card_frame;
	int        card_frames;

	int        ack_count;
	int        cycle_count;
	int        tests_run;
	int        tests_failed;
	string     test_name;
	outcome_t  expected;
	outcome_t  observed;
	event      outcome_ready;

	// released line reads high
	pullup (cmd_pin);

	cmd_phys cmd_phys_inst (
		.sd_clock(sd_clock),
		.reset(reset),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.cmd_to_send(cmd_to_send),
		.ack_out(ack_out),
		.strobe_out(strobe_out),
		.response(response),
		.cmd_pin(cmd_pin),
		.command_timeout(command_timeout)
	);

	sd_card_model card (
		.sd_clock(sd_clock),
		.reset(reset),
		.answer_en(card_answer),
		.resp_bits(card_resp),
		.resp_len(card_len),
		.gap_cycles(card_gap),
		.frame(card_frame),
		.frame_count(card_frames),
		.cmd_pin(cmd_pin)
	);

	initial begin
		sd_clock = 1'b0;
		forever #10 sd_clock = ~sd_clock;
	end

	always @(negedge sd_clock) begin
		if (reset) begin
			ack_count <= 0;
		end else if (ack_out) begin
			ack_count <= ack_count + 1;
		end
	end

	// crc7 as remainder of the division by x^7 + x^3 + 1
	function automatic sd_frame_t crc_frame(input sd_cmd_t cmd);
		logic [46:0] rem;
		rem = {cmd, 7'b0};
		for (int i = 46; i >= 7; i--) begin
			if (rem[i]) begin
				rem[i -: 8] = rem[i -: 8] ^ 8'h89;
			end
		end
		return {cmd, rem[6:0], 1'b1};
	endfunction

	function automatic sd_resp_class_t response_class(input sd_index_t index);
		sd_resp_class_t c;
		c.no_response = index inside {6'd0, 6'd4, 6'd15};
		c.length = (index inside {6'd2, 6'd9, 6'd10}) ? 8'd136 : 8'd48;
		return c;
	endfunction

	// start bit 0, transmission bit 1
	function automatic sd_cmd_t make_cmd(input sd_index_t index, input logic [31:0] arg);
		return {2'b01, index, arg};
	endfunction

	function automatic sd_resp_t random_response(input sd_len_t len);
		sd_resp_t r;
		r = {8'($urandom), $urandom, $urandom, $urandom, $urandom};
		r = r & ((sd_resp_t'(1) << len) - sd_resp_t'(1));
		// start and transmission bits low, end bit high
		r[len - 1] = 1'b0;
		r[len - 2] = 1'b0;
		r[0] = 1'b1;
		return r;
	endfunction

	task automatic send_strobe(input sd_cmd_t cmd);
		@(posedge sd_clock);
		#2;
		cmd_to_send = cmd;
		strobe_in = 1'b1;
		@(posedge sd_clock);
		#2;
		strobe_in = 1'b0;
	endtask

	task automatic report_outcome(input string name, input outcome_t exp, input outcome_t got);
		test_name = name;
		expected = exp;
		observed = got;
		-> outcome_ready;
		@(negedge sd_clock);
	endtask

	task automatic exchange_command(input string name, input sd_cmd_t cmd, input logic answer,
			input int hold);
		sd_resp_class_t cls;
		sd_resp_t       rsp;
		int             acks_before;
		int             frames_before;
		outcome_t       exp;
		outcome_t       got;
		cls = response_class(cmd[`SD_CMD_INDEX_MSB:`SD_CMD_INDEX_LSB]);
		rsp = (answer && !cls.no_response) ? random_response(cls.length) : '0;
		card_answer = answer && !cls.no_response;
		card_resp = rsp;
		card_len = cls.length;
		card_gap = $urandom_range(40, 2);
		exp.frame = crc_frame(cmd);
		exp.resp = rsp;
		exp.strobe = cls.no_response || answer;
		exp.timeout = !cls.no_response && !answer;
		exp.steady = 1'b1;
		exp.acks = 8'd1;
		got = '0;
		got.steady = 1'b1;
		acks_before = ack_count;
		frames_before = card_frames;
		send_strobe(cmd);
		@(negedge sd_clock);
		while (!strobe_out && !command_timeout) begin
			@(negedge sd_clock);
		end
		got.strobe = strobe_out;
		got.timeout = command_timeout;
		got.resp = strobe_out ? response : '0;
		// host holds back the ack while a second strobe goes unanswered
		for (int k = 0; k < hold; k++) begin
			@(posedge sd_clock);
			#2;
			strobe_in = (k == hold / 2);
			@(negedge sd_clock);
			if (!strobe_out || response !== got.resp) begin
				got.steady = 1'b0;
			end
		end
		if (got.strobe) begin
			@(posedge sd_clock);
			#2;
			ack_in = 1'b1;
			@(posedge sd_clock);
			#2;
			ack_in = 1'b0;
		end else begin
			repeat (5) begin
				@(negedge sd_clock);
				got.strobe = got.strobe | strobe_out;
			end
		end
		while (card_frames == frames_before) begin
			@(posedge sd_clock);
		end
		@(posedge sd_clock);
		#2;
		got.frame = card_frame;
		got.acks = 8'(ack_count - acks_before);
		report_outcome(name, exp, got);
	endtask

	task automatic abort_mid_frame(input string name, input sd_cmd_t cmd);
		int        acks_before;
		int        frames_before;
		sd_frame_t full_frame;
		outcome_t  exp;
		outcome_t  got;
		full_frame = crc_frame(cmd);
		exp = '0;
		// card sees the first 20 frame bits and then the pulled-up line
		exp.frame = {full_frame[47:28], {28{1'b1}}};
		exp.steady = 1'b1;
		exp.acks = 8'd1;
		got = '0;
		got.steady = 1'b1;
		card_answer = 1'b0;
		acks_before = ack_count;
		frames_before = card_frames;
		send_strobe(cmd);
		repeat (20) @(posedge sd_clock);
		#2;
		idle_in = 1'b1;
		@(posedge sd_clock);
		#2;
		idle_in = 1'b0;
		// pad register lets go of the line on this edge
		@(posedge sd_clock);
		repeat (10) begin
			@(negedge sd_clock);
			if (cmd_pin !== 1'b1) begin
				got.steady = 1'b0;
			end
			got.strobe = got.strobe | strobe_out;
			got.timeout = got.timeout | command_timeout;
		end
		while (card_frames == frames_before) begin
			@(posedge sd_clock);
		end
		@(posedge sd_clock);
		#2;
		got.frame = card_frame;
		got.acks = 8'(ack_count - acks_before);
		report_outcome(name, exp, got);
	endtask

	initial begin : compare
		logic bad;
		tests_run = 0;
		tests_failed = 0;
		forever begin
			@(outcome_ready);
			bad = 1'b0;
			assert (observed.frame === expected.frame) else begin
				$display("[FAIL] %0t cmd_pin frame: got %h expected %h",
					$time, observed.frame, expected.frame);
				bad = 1'b1;
			end
			assert (observed.resp === expected.resp) else begin
				$display("[FAIL] %0t response: got %h expected %h",
					$time, observed.resp, expected.resp);
				bad = 1'b1;
			end
			assert (observed.strobe === expected.strobe) else begin
				$display("[FAIL] %0t strobe_out: got %b expected %b",
					$time, observed.strobe, expected.strobe);
				bad = 1'b1;
			end
			assert (observed.timeout === expected.timeout) else begin
				$display("[FAIL] %0t command_timeout: got %b expected %b",
					$time, observed.timeout, expected.timeout);
				bad = 1'b1;
			end
			assert (observed.acks === expected.acks) else begin
				$display("[FAIL] %0t ack_out pulses: got %0d expected %0d",
					$time, observed.acks, expected.acks);
				bad = 1'b1;
			end
			assert (observed.steady === expected.steady) else begin
				$display("%0t %s: line or held response did not stay steady", $time, test_name);
				bad = 1'b1;
			end
			tests_run = tests_run + 1;
			if (bad) begin
				tests_failed = tests_failed + 1;
			end
			$display("%s %s", test_name, bad ? "failed" : "ok");
		end
	end

	initial begin : stimulus
		sd_cmd_t cmd;
		reset = 1'b1;
		strobe_in = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		cmd_to_send = '0;
		card_answer = 1'b0;
		card_resp = '0;
		card_len = 8'd48;
		card_gap = 2;
		void'($urandom(32'h4bec_1ebe));
		repeat (3) @(posedge sd_clock);
		#2;
		reset = 1'b0;
		exchange_command("short_cmd17", make_cmd(6'd17, 32'h1234_abcd), 1'b1, 0);
		exchange_command("long_cmd2", make_cmd(6'd2, 32'h0000_0000), 1'b1, 0);
		exchange_command("no_resp_cmd0", make_cmd(6'd0, 32'h0000_0000), 1'b1, 0);
		exchange_command("silent_cmd17", make_cmd(6'd17, 32'h0000_0200), 1'b0, 0);
		exchange_command("after_timeout", make_cmd(6'd17, 32'h0000_0400), 1'b1, 0);
		exchange_command("back_pressure", make_cmd(6'd13, 32'h0001_0000), 1'b1, 50);
		abort_mid_frame("abort", make_cmd(6'd24, 32'hdead_beef));
		exchange_command("after_abort", make_cmd(6'd17, 32'h0000_0600), 1'b1, 0);
		for (int i = 0; i < 20; i++) begin
			cmd = make_cmd(6'($urandom_range(63, 0)), $urandom);
			exchange_command($sformatf("random_%0d", i), cmd, 1'b1, 0);
		end
		repeat (2) @(posedge sd_clock);
		$display("%0d tests run, %0d failed", tests_run, tests_failed);
		if (tests_failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < max_cycles) begin
			@(posedge sd_clock);
			cycle_count = cycle_count + 1;
		end
		$display("run stopped after %0d cycles without finishing", max_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* bench/sd_card_model.sv */
`timescale 1ns/1ps
`include "sd_cmd_defines.svh"

module sd_card_model import sd_cmd_pkg::*; (
	input  logic      sd_clock,
	input  logic      reset,
	input  logic      answer_en,
	input  sd_resp_t  resp_bits,
	input  sd_len_t   resp_len,
	input  int        gap_cycles,
	output sd_frame_t frame,
	output int        frame_count,
	inout  wire       cmd_pin
);

	logic drive_q;
	logic bit_q;

	assign cmd_pin = drive_q ? bit_q : 1'bz;

	// sampled on the falling edge, mid-bit
	task automatic capture_frame();
		sd_frame_t bits;
		bits = '0;
		@(negedge sd_clock);
		while (cmd_pin !== 1'b0) begin
			@(negedge sd_clock);
		end
		// start bit is already on the line here
		for (int i = 0; i < `SD_CMD_FRAME_BITS; i++) begin
			bits = {bits[`SD_CMD_FRAME_BITS-2:0], cmd_pin};
			if (i < `SD_CMD_FRAME_BITS - 1) begin
				@(negedge sd_clock);
			end
		end
		frame = bits;
		frame_count = frame_count + 1;
	endtask

	// msb first, start bit included in resp_bits
	task automatic send_response();
		repeat (gap_cycles) @(posedge sd_clock);
		#2;
		for (int i = resp_len - 1; i >= 0; i--) begin
			bit_q = resp_bits[i];
			drive_q = 1'b1;
			@(posedge sd_clock);
			#2;
		end
		drive_q = 1'b0;
		bit_q = 1'b1;
	endtask

	initial begin
		drive_q = 1'b0;
		bit_q = 1'b1;
		frame = '0;
		frame_count = 0;
		@(negedge reset);
		forever begin
			capture_frame();
			if (answer_en) begin
				send_response();
			end
		end
	end

endmodule

/* hdl/cmd_phys.sv */
`timescale 1ns/1ps
`include "sd_cmd_defines.svh"

module cmd_phys import sd_cmd_pkg::*; #(
	parameter int ncr_cycles = `SD_CMD_NCR
) (
	input  logic     sd_clock,
	input  logic     reset,
	input  logic     strobe_in,
	input  logic     ack_in,
	input  logic     idle_in,
	input  sd_cmd_t  cmd_to_send,
	output logic     ack_out,
	output logic     strobe_out,
	output sd_resp_t response,
	inout  wire      cmd_pin,
	output logic     command_timeout
);

	sd_cmd_t        cmd_q;
	sd_index_t      cmd_index;
	logic           no_resp;
	logic           long_resp;
	sd_resp_class_t resp_class;

	logic     ser_load;
	logic     ser_shift_en;
	logic     ser_serial;
	logic     ser_done;
	logic     drive_en;
	logic     pad_rx;
	logic     rx_en;
	logic     rx_start_seen;
	logic     rx_done;
	sd_resp_t rx_data;

	// host keeps cmd_to_send valid on the strobe cycle only
	always_ff @(posedge sd_clock) begin
		if (strobe_in) begin
			cmd_q <= cmd_to_send;
		end
	end

	// response class from the index
	assign cmd_index = cmd_q[`SD_CMD_INDEX_MSB:`SD_CMD_INDEX_LSB];
	assign no_resp = (cmd_index == 6'd0) || (cmd_index == 6'd4) || (cmd_index == 6'd15);
	assign long_resp = (cmd_index == 6'd2) || (cmd_index == 6'd9) || (cmd_index == 6'd10);
	assign resp_class = '{
		no_response: no_resp,
		length: long_resp ? sd_len_t'(`SD_CMD_LONG_BITS) : sd_len_t'(`SD_CMD_FRAME_BITS)
	};

	cmd_serializer ser (
		.sd_clock(sd_clock),
		.reset(reset),
		.load(ser_load),
		.shift_en(ser_shift_en),
		.cmd(cmd_q),
		.serial(ser_serial),
		.done(ser_done)
	);

	cmd_deserializer deser (
		.sd_clock(sd_clock),
		.reset(reset),
		.rx_en(rx_en),
		.length(resp_class.length),
		.serial(pad_rx),
		.start_seen(rx_start_seen),
		.done(rx_done),
		.data(rx_data)
	);

	cmd_pad pad (
		.sd_clock(sd_clock),
		.reset(reset),
		.drive_en(drive_en),
		.data_in(ser_serial),
		.data_out(pad_rx),
		.cmd_pin(cmd_pin)
	);

	cmd_phys_controller #(
		.ncr_cycles(ncr_cycles)
	) cpc (
		.sd_clock(sd_clock),
		.reset(reset),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.resp_class(resp_class),
		.ser_done(ser_done),
		.rx_start_seen(rx_start_seen),
		.rx_done(rx_done),
		.rx_data(rx_data),
		.ack_out(ack_out),
		.strobe_out(strobe_out),
		.ser_load(ser_load),
		.ser_shift_en(ser_shift_en),
		.drive_en(drive_en),
		.rx_en(rx_en),
		.command_timeout(command_timeout),
		.response(response)
	);

endmodule

/* hdl/cmd_phys_controller.sv */
`timescale 1ns/1ps
`include "sd_cmd_defines.svh"

module cmd_phys_controller import sd_cmd_pkg::*; #(
	parameter int ncr_cycles = `SD_CMD_NCR
) (
	input  logic           sd_clock,
	input  logic           reset,
	input  logic           strobe_in,
	input  logic           ack_in,
	input  logic           idle_in,
	input  sd_resp_class_t resp_class,
	input  logic           ser_done,
	input  logic           rx_start_seen,
	input  logic           rx_done,
	input  sd_resp_t       rx_data,
	output logic           ack_out,
	output logic           strobe_out,
	output logic           ser_load,
	output logic           ser_shift_en,
	output logic           drive_en,
	output logic           rx_en,
	output logic           command_timeout,
	output sd_resp_t       response
);

	// the synchroniser lag is added on top of the card's window
	localparam int win_limit = ncr_cycles + `SD_CMD_SYNC_STAGES;
	localparam int win_width = $clog2(win_limit + 1);

	cpc_state_e           state_q;
	logic [win_width-1:0] win_count_q;
	logic                 win_expired;
	logic                 rx_armed;

	assign win_expired = (win_count_q == win_width'(win_limit - 1));

	// our own last bits are still in the synchroniser right after release
	assign rx_armed = (win_count_q >= win_width'(`SD_CMD_SYNC_STAGES));

	always_ff @(posedge sd_clock) begin
		if (reset) begin
			state_q <= CPC_IDLE;
			ack_out <= 1'b0;
			command_timeout <= 1'b0;
			response <= '0;
			win_count_q <= '0;
		end else begin
			ack_out <= 1'b0;
			if (idle_in) begin
				state_q <= CPC_IDLE;
			end else begin
				case (state_q)
					CPC_IDLE: begin
						if (strobe_in) begin
							ack_out <= 1'b1;
							command_timeout <= 1'b0;
							state_q <= CPC_LOAD;
						end
					end
					CPC_LOAD: begin
						state_q <= CPC_SEND;
					end
					CPC_SEND: begin
						win_count_q <= '0;
						if (ser_done) begin
							if (resp_class.no_response) begin
								// nothing comes back, hand over zeros
								response <= '0;
								state_q <= CPC_DELIVER;
							end else begin
								state_q <= CPC_WAIT_START;
							end
						end
					end
					CPC_WAIT_START: begin
						win_count_q <= win_count_q + 1'b1;
						if (rx_start_seen) begin
							state_q <= CPC_RECEIVE;
						end else if (win_expired) begin
							command_timeout <= 1'b1;
							state_q <= CPC_IDLE;
						end
					end
					CPC_RECEIVE: begin
						if (rx_done) begin
							response <= rx_data;
							state_q <= CPC_DELIVER;
						end
					end
					CPC_DELIVER: begin
						// held here until the host takes the response
						if (ack_in) begin
							state_q <= CPC_IDLE;
						end
					end
					default: begin
						state_q <= CPC_IDLE;
					end
				endcase
			end
		end
	end

	assign ser_load = (state_q == CPC_LOAD);
	assign ser_shift_en = (state_q == CPC_SEND);
	assign drive_en = (state_q == CPC_SEND);
	// rx_en stays high from arming through the whole reception
	assign rx_en = (state_q == CPC_RECEIVE) || ((state_q == CPC_WAIT_START) && rx_armed);
	assign strobe_out = (state_q == CPC_DELIVER);

	a_no_drive_in_deliver: assert property (
		@(posedge sd_clock) disable iff (reset) !(strobe_out && drive_en)
	) else $error("cmd_phys_controller: line driven while a response is presented");

	a_ack_single_cycle: assert property (
		@(posedge sd_clock) disable iff (reset) ack_out |=> !ack_out
	) else $error("cmd_phys_controller: ack_out held for two cycles");

endmodule

/* hdl/cmd_pad.sv */
`timescale 1ns/1ps
`include "sd_cmd_defines.svh"

module cmd_pad (
	input  logic sd_clock,
	input  logic reset,
	input  logic drive_en,
	input  logic data_in,
	output logic data_out,
	inout  wire  cmd_pin
);

	logic                           drive_q;
	logic                           data_q;
	logic [`SD_CMD_SYNC_STAGES-1:0] sync_q;

	always_ff @(posedge sd_clock) begin
		if (reset) begin
			drive_q <= 1'b0;
		end else begin
			drive_q <= drive_en;
		end
	end

	always_ff @(posedge sd_clock) begin
		data_q <= data_in;
	end

	// released line is pulled high on the board
	assign cmd_pin = drive_q ? data_q : 1'bz;

	always_ff @(posedge sd_clock) begin
		if (reset) begin
			sync_q <= '1;
		end else begin
			sync_q <= {sync_q[`SD_CMD_SYNC_STAGES-2:0], cmd_pin};
		end
	end

	assign data_out = sync_q[`SD_CMD_SYNC_STAGES-1];

endmodule

/* hdl/cmd_deserializer.sv */
`timescale 1ns/1ps
`include "sd_cmd_defines.svh"

module cmd_deserializer import sd_cmd_pkg::*; (
	input  logic     sd_clock,
	input  logic     reset,
	input  logic     rx_en,
	input  sd_len_t  length,
	input  logic     serial,
	output logic     start_seen,
	output logic     done,
	output sd_resp_t data
);

	sd_len_t count_q;
	logic    active_q;
	logic    start_bit;
	logic    last_bit;

	// first 0 on the line while hunting
	assign start_bit = rx_en && !start_seen && !serial;
	assign last_bit = active_q && (count_q == length - 8'd1);

	always_ff @(posedge sd_clock) begin
		if (reset || !rx_en) begin
			start_seen <= 1'b0;
			active_q <= 1'b0;
			count_q <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start_bit) begin
				start_seen <= 1'b1;
				active_q <= 1'b1;
				// start bit already counts as the first one
				count_q <= 8'd1;
			end else if (active_q) begin
				count_q <= count_q + 8'd1;
				if (last_bit) begin
					active_q <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// clearing on the start bit keeps short responses right-aligned
	always_ff @(posedge sd_clock) begin
		if (start_bit) begin
			data <= '0;
		end else if (rx_en && active_q) begin
			data <= {data[`SD_CMD_LONG_BITS-2:0], serial};
		end
	end

	a_length_legal: assert property (
		@(posedge sd_clock) disable iff (reset)
		rx_en |-> (length == sd_len_t'(`SD_CMD_FRAME_BITS) ||
			length == sd_len_t'(`SD_CMD_LONG_BITS))
	) else $error("cmd_deserializer: unexpected response length %0d", length);

endmodule

/* hdl/cmd_serializer.sv */
`timescale 1ns/1ps
`include "sd_cmd_defines.svh"

module cmd_serializer import sd_cmd_pkg::*; (
	input  logic    sd_clock,
	input  logic    reset,
	input  logic    load,
	input  logic    shift_en,
	input  sd_cmd_t cmd,
	output logic    serial,
	output logic    done
);

	sd_frame_t shift_q;
	sd_len_t   count_q;
	logic      busy_q;
	sd_crc_t   crc;

	// crc7, x^7 + x^3 + 1, fed msb first
	function automatic sd_crc_t crc7(input sd_cmd_t bits);
		sd_crc_t c;
		logic    fb;
		c = '0;
		for (int i = `SD_CMD_CMD_BITS - 1; i >= 0; i--) begin
			fb = bits[i] ^ c[`SD_CMD_CRC_BITS-1];
			c = {c[`SD_CMD_CRC_BITS-2:0], 1'b0};
			if (fb) begin
				c = c ^ 7'h09;
			end
		end
		return c;
	endfunction

	assign crc = crc7(cmd);

	always_ff @(posedge sd_clock) begin
		if (reset) begin
			busy_q <= 1'b0;
			count_q <= '0;
		end else if (load) begin
			busy_q <= 1'b1;
			count_q <= '0;
		end else if (busy_q && shift_en) begin
			count_q <= count_q + 8'd1;
			if (done) begin
				busy_q <= 1'b0;
			end
		end else begin
			// enable dropped mid-frame, give up the frame
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge sd_clock) begin
		if (load) begin
			shift_q <= {cmd, crc, 1'b1};
		end else if (busy_q && shift_en) begin
			shift_q <= {shift_q[`SD_CMD_FRAME_BITS-2:0], 1'b1};
		end
	end

	// line idles high between frames
	assign serial = busy_q ? shift_q[`SD_CMD_FRAME_BITS-1] : 1'b1;
	assign done = busy_q && shift_en && (count_q == sd_len_t'(`SD_CMD_FRAME_BITS - 1));

	a_no_load_while_shifting: assert property (
		@(posedge sd_clock) disable iff (reset) load |-> !busy_q
	) else $error("cmd_serializer: load while a frame is being shifted");

endmodule

/* hdl/sd_cmd_pkg.sv */
`include "sd_cmd_defines.svh"

package sd_cmd_pkg;

	// start bit, transmission bit, index, argument
	typedef logic [`SD_CMD_CMD_BITS-1:0] sd_cmd_t;
	typedef logic [`SD_CMD_FRAME_BITS-1:0] sd_frame_t;
	// right-aligned, upper bits zero for short responses
	typedef logic [`SD_CMD_LONG_BITS-1:0] sd_resp_t;
	typedef logic [`SD_CMD_CRC_BITS-1:0] sd_crc_t;
	typedef logic [5:0] sd_index_t;
	typedef logic [7:0] sd_len_t;

	// what the card is expected to send back for an index
	typedef struct packed {
		logic    no_response;
		sd_len_t length;
	} sd_resp_class_t;

	typedef enum logic [2:0] {
		CPC_IDLE,
		CPC_LOAD,
		CPC_SEND,
		CPC_WAIT_START,
		CPC_RECEIVE,
		CPC_DELIVER
	} cpc_state_e;

endpackage

/* hdl/sd_cmd_defines.svh */
`ifndef SD_CMD_DEFINES_SVH
`define SD_CMD_DEFINES_SVH

// command as handed over by the host
`define SD_CMD_CMD_BITS 40
`define SD_CMD_CRC_BITS 7

// host frame, also the length of a short response
`define SD_CMD_FRAME_BITS 48
`define SD_CMD_LONG_BITS 136

// index field inside the 40-bit command
`define SD_CMD_INDEX_MSB 37
`define SD_CMD_INDEX_LSB 32

// cycles after release for the card's start bit
`define SD_CMD_NCR 64

`define SD_CMD_SYNC_STAGES 2

`endif
